// File: rtl/ttc_pkg.sv
package ttc_pkg;

   // ------------------------------------------------------------------------
   // Widths
   // ------------------------------------------------------------------------
   localparam int CNT_W       = 16;           // Counter, interval, match
   localparam int REG_IDX_W   = 4;            // Word index inside one timer
   localparam int APB_ADDR_W  = 8;
   localparam int TMR_NUM_W   = 2;            // Timer number field of paddr
   localparam int IDX_LSB     = 2;            // paddr[5:2]
   localparam int TMR_LSB     = 6;            // paddr[7:6]
   localparam int CLK_CTRL_W  = 7;
   localparam int CNTR_CTRL_W = 7;
   localparam int INT_W       = 6;
   localparam int PRE_DIV_W   = 17;           // Prescaler divider
   localparam int PRE_SEL_W   = 4;

   // ------------------------------------------------------------------------
   // Register indices
   // ------------------------------------------------------------------------
   localparam logic [REG_IDX_W-1:0] REG_CLK_CTRL   = 4'd0;
   localparam logic [REG_IDX_W-1:0] REG_CNTR_CTRL  = 4'd1;
   localparam logic [REG_IDX_W-1:0] REG_COUNTER    = 4'd2;  // Read only
   localparam logic [REG_IDX_W-1:0] REG_INTERVAL   = 4'd3;
   localparam logic [REG_IDX_W-1:0] REG_MATCH_1    = 4'd4;
   localparam logic [REG_IDX_W-1:0] REG_MATCH_2    = 4'd5;
   localparam logic [REG_IDX_W-1:0] REG_MATCH_3    = 4'd6;
   localparam logic [REG_IDX_W-1:0] REG_INT_STATUS = 4'd7;  // Clear on read
   localparam logic [REG_IDX_W-1:0] REG_INT_EN     = 4'd8;

   // Control fields
   localparam int PRE_EN_BIT     = 0;         // clk_ctrl prescale enable
   localparam int PRE_SEL_LSB    = 1;         // clk_ctrl[4:1], select n
   localparam int CNTR_DIS_BIT   = 0;
   localparam int CNTR_INT_BIT   = 1;         // Interval mode
   localparam int CNTR_MATCH_BIT = 3;
   localparam int CNTR_RST_BIT   = 4;         // Self clearing
   localparam logic [CNTR_CTRL_W-1:0] CNTR_CTRL_RST = 7'h01;  // Disabled

   // Status bits, match k sits at INT_MATCH_LSB + k - 1
   localparam int INT_INTERVAL  = 0;
   localparam int INT_MATCH_LSB = 1;
   localparam int INT_OVERFLOW  = 4;

   typedef logic [31:0] ttc_data_t;           // APB data word
   typedef logic [3:1]  ttc_irq_t;            // One line per timer

   // Register interface to timer
   typedef struct packed {
      logic             clk_ctrl_sel;
      logic             cntr_ctrl_sel;
      logic             interval_sel;
      logic [3:1]       match_sel;
      logic             int_en_sel;
      logic             status_clr;           // Access phase of status read
      logic [CNT_W-1:0] wdata;
   } ttc_wr_t;

   // Timer back to register interface
   typedef struct packed {
      logic [CLK_CTRL_W-1:0]  clk_ctrl;
      logic [CNTR_CTRL_W-1:0] cntr_ctrl;
      logic [CNT_W-1:0]       counter;
      logic [CNT_W-1:0]       interval;
      logic [3:1][CNT_W-1:0]  match;
      logic [INT_W-1:0]       int_status;
      logic [INT_W-1:0]       int_en;
   } ttc_rd_t;

endpackage

// File: rtl/ttc_prescaler.sv
`timescale 1ns/100ps

module ttc_prescaler
   import ttc_pkg::*;
(
   input  logic                  pclk,
   input  logic                  rst,
   input  logic [CLK_CTRL_W-1:0] clk_ctrl,
   output logic                  tick
);

   logic [PRE_DIV_W-1:0]  div_cnt;            // Free running divider
   logic [PRE_DIV_W-1:0]  div_mask;           // Low n+1 bits set
   logic [PRE_SEL_W-1:0]  pre_sel;
   logic [CLK_CTRL_W-1:0] ctrl_q;             // Last seen clk_ctrl
   logic                  ctrl_chg;

   assign pre_sel  = clk_ctrl[PRE_SEL_LSB +: PRE_SEL_W];
   assign ctrl_chg = (clk_ctrl != ctrl_q);
   assign div_mask = (PRE_DIV_W'(1) << (5'(pre_sel) + 5'd1)) - PRE_DIV_W'(1);

   // Every cycle when bypassed, else once per 2^(n+1)
   // No tick on the cycle the divider restarts
   assign tick = ~clk_ctrl[PRE_EN_BIT] |
                 (~ctrl_chg & ((div_cnt & div_mask) == div_mask));

   always_ff @(posedge pclk) begin
      if (rst) begin
         div_cnt <= '0;
         ctrl_q  <= '0;
      end else begin
         ctrl_q <= clk_ctrl;
         if (ctrl_chg)
            div_cnt <= '0;                    // Restart after a write
         else
            div_cnt <= div_cnt + 1'b1;
      end
   end

endmodule

// File: rtl/ttc_timer_counter.sv
`timescale 1ns/100ps

module ttc_timer_counter
   import ttc_pkg::*;
(
   input  logic                  pclk,
   input  logic                  rst,
   input  ttc_wr_t               wr,
   input  logic                  tick,
   output ttc_rd_t               rd,
   output logic [CLK_CTRL_W-1:0] clk_ctrl,
   output logic                  interrupt
);

   logic [CNTR_CTRL_W-1:0] cntr_ctrl;
   logic [CNT_W-1:0]       count;
   logic [CNT_W-1:0]       count_nxt;
   logic [CNT_W-1:0]       interval;
   logic [3:1][CNT_W-1:0]  match;
   logic [INT_W-1:0]       int_status;
   logic [INT_W-1:0]       int_en;
   logic [INT_W-1:0]       int_evt;           // Events on this edge
   logic                   cnt_clr;
   logic                   cnt_adv;
   logic                   int_mode;
   logic                   wrap;

   // ------------------------------------------------------------------------
   // Software registers
   // ------------------------------------------------------------------------
   always_ff @(posedge pclk) begin
      if (rst) begin
         clk_ctrl  <= '0;
         cntr_ctrl <= CNTR_CTRL_RST;
         interval  <= '0;
         match     <= '0;
         int_en    <= '0;
      end else begin
         if (wr.clk_ctrl_sel)
            clk_ctrl <= wr.wdata[CLK_CTRL_W-1:0];
         if (wr.cntr_ctrl_sel) begin
            cntr_ctrl               <= wr.wdata[CNTR_CTRL_W-1:0];
            cntr_ctrl[CNTR_RST_BIT] <= 1'b0;  // Pulse only, never stored
         end
         if (wr.interval_sel)
            interval <= wr.wdata;
         for (int k = 1; k <= 3; k++) begin
            if (wr.match_sel[k])
               match[k] <= wr.wdata;
         end
         if (wr.int_en_sel)
            int_en <= wr.wdata[INT_W-1:0];
      end
   end

   // ------------------------------------------------------------------------
   // Counter
   // ------------------------------------------------------------------------
   assign cnt_clr  = wr.cntr_ctrl_sel & wr.wdata[CNTR_RST_BIT];
   assign cnt_adv  = tick & ~cntr_ctrl[CNTR_DIS_BIT] & ~cnt_clr;
   assign int_mode = cntr_ctrl[CNTR_INT_BIT];
   // >= so a lowered interval still wraps
   assign wrap      = int_mode & (count >= interval);
   assign count_nxt = wrap ? '0 : count + 1'b1;  // Free run rolls over

   // Status events, only on an advancing edge
   always_comb begin
      int_evt = '0;
      if (cnt_adv) begin
         int_evt[INT_INTERVAL] = wrap;
         int_evt[INT_OVERFLOW] = ~int_mode & (count == '1);
         if (cntr_ctrl[CNTR_MATCH_BIT]) begin
            for (int k = 1; k <= 3; k++)
               int_evt[INT_MATCH_LSB+k-1] = (count_nxt == match[k]);  // New value
         end
      end
   end

   always_ff @(posedge pclk) begin
      if (rst) begin
         count      <= '0;
         int_status <= '0;
      end else begin
         if (cnt_clr)
            count <= '0;
         else if (cnt_adv)
            count <= count_nxt;
         // Set wins over clear on read
         int_status <= (int_status & ~{INT_W{wr.status_clr}}) | int_evt;
      end
   end

   assign interrupt = |(int_status & int_en);

   // Read back
   always_comb begin
      rd            = '0;
      rd.clk_ctrl   = clk_ctrl;
      rd.cntr_ctrl  = cntr_ctrl;
      rd.counter    = count;
      rd.interval   = interval;
      rd.match      = match;
      rd.int_status = int_status;
      rd.int_en     = int_en;
   end

   // ------------------------------------------------------------------------
   // Checks
   // ------------------------------------------------------------------------
   // Once inside the interval, the counter stays inside while it is unchanged
   a_int_bound: assert property (@(posedge pclk) disable iff (rst)
      (int_mode && $past(int_mode) && $stable(interval) && $past(count <= interval))
      |-> (count <= interval))
      else $error("counter %0h above interval %0h", count, interval);

   // Counter reset write clears the count and leaves bit 4 low
   a_cntr_rst_low: assert property (@(posedge pclk) disable iff (rst)
      cnt_clr |=> (count == '0) && !rd.cntr_ctrl[CNTR_RST_BIT])
      else $error("counter reset left count %0h, control %0h", count, cntr_ctrl);

endmodule

// File: rtl/ttc_apb_regif.sv
`timescale 1ns/100ps

module ttc_apb_regif
   import ttc_pkg::*;
#(
   parameter int NUM_TIMERS = 3
) (
   input  logic                  pclk,
   input  logic                  rst,
   input  logic                  psel,
   input  logic                  penable,
   input  logic                  pwrite,
   input  logic [APB_ADDR_W-1:0] paddr,
   input  ttc_data_t             pwdata,
   input  ttc_rd_t               timer_rd [1:NUM_TIMERS],
   output ttc_data_t             prdata,
   output ttc_wr_t               timer_wr [1:NUM_TIMERS]
);

   logic [TMR_NUM_W-1:0] tmr_num;
   logic [REG_IDX_W-1:0] reg_idx;
   logic                 wr_access;           // Access phase of a write
   logic                 rd_access;           // Access phase of a read
   logic                 rd_phase;            // Setup or access of a read
   logic [NUM_TIMERS:1]  tmr_sel;             // Any strobe per timer

   assign tmr_num   = paddr[TMR_LSB +: TMR_NUM_W];
   assign reg_idx   = paddr[IDX_LSB +: REG_IDX_W];
   assign wr_access = psel & penable & pwrite;
   assign rd_access = psel & penable & ~pwrite;
   assign rd_phase  = psel & ~pwrite;

   // Zero extended read word of one timer
   function automatic ttc_data_t rd_word(input ttc_rd_t rd,
                                         input logic [REG_IDX_W-1:0] idx);
      ttc_data_t word;
      word = '0;
      case (idx)
         REG_CLK_CTRL:   word = ttc_data_t'(rd.clk_ctrl);
         REG_CNTR_CTRL:  word = ttc_data_t'(rd.cntr_ctrl);
         REG_COUNTER:    word = ttc_data_t'(rd.counter);
         REG_INTERVAL:   word = ttc_data_t'(rd.interval);
         REG_MATCH_1:    word = ttc_data_t'(rd.match[1]);
         REG_MATCH_2:    word = ttc_data_t'(rd.match[2]);
         REG_MATCH_3:    word = ttc_data_t'(rd.match[3]);
         REG_INT_STATUS: word = ttc_data_t'(rd.int_status);
         REG_INT_EN:     word = ttc_data_t'(rd.int_en);
         default:        word = '0;          // 9 to 15 unmapped
      endcase
      return word;
   endfunction

   // ------------------------------------------------------------------------
   // Per timer decode
   // ------------------------------------------------------------------------
   for (genvar t = 1; t <= NUM_TIMERS; t++) begin : g_dec
      logic hit;

      assign hit = (tmr_num == TMR_NUM_W'(t));  // Timer 0 never hits

      always_comb begin
         timer_wr[t]       = '0;
         timer_wr[t].wdata = pwdata[CNT_W-1:0];
         if (hit && wr_access) begin
            case (reg_idx)
               REG_CLK_CTRL:  timer_wr[t].clk_ctrl_sel  = 1'b1;
               REG_CNTR_CTRL: timer_wr[t].cntr_ctrl_sel = 1'b1;
               REG_INTERVAL:  timer_wr[t].interval_sel  = 1'b1;
               REG_MATCH_1:   timer_wr[t].match_sel[1]  = 1'b1;
               REG_MATCH_2:   timer_wr[t].match_sel[2]  = 1'b1;
               REG_MATCH_3:   timer_wr[t].match_sel[3]  = 1'b1;
               REG_INT_EN:    timer_wr[t].int_en_sel    = 1'b1;
               default:       ;                  // Read only or unmapped
            endcase
         end
         timer_wr[t].status_clr = hit & rd_access & (reg_idx == REG_INT_STATUS);
      end

      assign tmr_sel[t] = |{timer_wr[t].clk_ctrl_sel, timer_wr[t].cntr_ctrl_sel,
                             timer_wr[t].interval_sel, timer_wr[t].match_sel,
                             timer_wr[t].int_en_sel, timer_wr[t].status_clr};
   end

   // Read mux, zero outside a read
   always_comb begin
      prdata = '0;
      for (int t = 1; t <= NUM_TIMERS; t++) begin
         if (rd_phase && tmr_num == TMR_NUM_W'(t))
            prdata = rd_word(timer_rd[t], reg_idx);
      end
   end

   // ------------------------------------------------------------------------
   // Checks
   // ------------------------------------------------------------------------
   a_one_timer_sel: assert property (@(posedge pclk) disable iff (rst)
      $onehot0(tmr_sel))
      else $error("more than one timer selected: %b", tmr_sel);

endmodule

// File: rtl/ttc_lite.sv
`timescale 1ns/100ps

module ttc_lite
   import ttc_pkg::*;
#(
   parameter int NUM_TIMERS = 3
) (
   input  logic                  pclk,
   input  logic                  rst,
   input  logic                  psel,
   input  logic                  penable,
   input  logic                  pwrite,
   input  logic [APB_ADDR_W-1:0] paddr,
   input  ttc_data_t             pwdata,
   output ttc_data_t             prdata,
   output ttc_irq_t              interrupt
);

   ttc_wr_t timer_wr [1:NUM_TIMERS];          // Strobes and write data
   ttc_rd_t timer_rd [1:NUM_TIMERS];          // Register contents

   // ------------------------------------------------------------------------
   // APB decode
   // ------------------------------------------------------------------------
   ttc_apb_regif #(
      .NUM_TIMERS (NUM_TIMERS)
   ) regif_inst (
      .pclk     (pclk),
      .rst      (rst),
      .psel     (psel),
      .penable  (penable),
      .pwrite   (pwrite),
      .paddr    (paddr),
      .pwdata   (pwdata),
      .timer_rd (timer_rd),
      .prdata   (prdata),
      .timer_wr (timer_wr)
   );

   // ------------------------------------------------------------------------
   // Timers, numbered from 1
   // ------------------------------------------------------------------------
   for (genvar t = 1; t <= NUM_TIMERS; t++) begin : g_timer
      logic [CLK_CTRL_W-1:0] clk_ctrl;
      logic                  tick;            // Count enable

      ttc_prescaler prescaler_inst (
         .pclk     (pclk),
         .rst      (rst),
         .clk_ctrl (clk_ctrl),
         .tick     (tick)
      );

      ttc_timer_counter timer_inst (
         .pclk      (pclk),
         .rst       (rst),
         .wr        (timer_wr[t]),
         .tick      (tick),
         .rd        (timer_rd[t]),
         .clk_ctrl  (clk_ctrl),
         .interrupt (interrupt[t])
      );
   end

endmodule

// File: verif/ttc_lite_tb.sv
`timescale 1ns/100ps

module ttc_lite_tb
   import ttc_pkg::*;
();

   localparam int HALF_PERIOD = 10;           // 20 ns clock
   localparam int RST_CYCLES  = 10;
   localparam int MAX_GAP     = 4;            // Idle gap before a read, 0 to 3

   logic                  pclk;
   logic                  rst;
   logic                  psel;
   logic                  penable;
   logic                  pwrite;
   logic [APB_ADDR_W-1:0] paddr;
   ttc_data_t             pwdata;
   ttc_data_t             prdata;
   ttc_irq_t              interrupt;

   int                    num_ops;            // Vector lines executed

   ttc_lite #(
      .NUM_TIMERS (3)
   ) ttc_lite_inst (
      .pclk      (pclk),
      .rst       (rst),
      .psel      (psel),
      .penable   (penable),
      .pwrite    (pwrite),
      .paddr     (paddr),
      .pwdata    (pwdata),
      .prdata    (prdata),
      .interrupt (interrupt)
   );

   always #HALF_PERIOD pclk = ~pclk;

   // ------------------------------------------------------------------------
   // Checks
   // ------------------------------------------------------------------------
   task automatic end_with_failure();
      $display("tests failed");
      $fatal(1);
   endtask

   task automatic check_data(input string name, input ttc_data_t exp, input ttc_data_t act);
      if (act !== exp) begin
         $display("ERROR %s: expected %08h, actual %08h", name, exp, act);
         end_with_failure();
      end
   endtask

   task automatic check_irq(input string name, input ttc_irq_t exp, input ttc_irq_t act);
      if (act !== exp) begin
         $display("ERROR %s: expected irq %0h, actual irq %0h", name, exp, act);
         end_with_failure();
      end
   endtask

   // ------------------------------------------------------------------------
   // APB master, every task starts and ends on a falling edge
   // ------------------------------------------------------------------------
   task automatic apb_write(input logic [APB_ADDR_W-1:0] addr, input ttc_data_t data);
      @(negedge pclk);                        // Setup
      psel    = 1'b1;
      pwrite  = 1'b1;
      paddr   = addr;
      pwdata  = data;
      @(negedge pclk);
      penable = 1'b1;                         // Write lands on the next rise
      @(negedge pclk);
      psel    = 1'b0;
      penable = 1'b0;
   endtask

   // Random gap only here, so write to write spacing stays exact
   task automatic apb_read(input logic [APB_ADDR_W-1:0] addr, output ttc_data_t data);
      repeat ($urandom % MAX_GAP) @(negedge pclk);
      @(negedge pclk);
      psel    = 1'b1;
      pwrite  = 1'b0;
      paddr   = addr;
      @(negedge pclk);
      penable = 1'b1;
      #1 data = prdata;                       // Settled, clear on read not yet
      @(negedge pclk);
      psel    = 1'b0;
      penable = 1'b0;
   endtask

   task automatic wait_irq(input string name, input ttc_irq_t exp, input int limit);
      int cycles;
      cycles = 0;
      while (interrupt !== exp && cycles < limit) begin
         @(negedge pclk);
         cycles++;
      end
      if (interrupt !== exp) begin
         $display("%s: interrupt vector %0h not seen within %0d cycles, still %0h",
                  name, exp, limit, interrupt);
         end_with_failure();
      end
   endtask

   // ------------------------------------------------------------------------
   // Extra register and interrupt checks
   // ------------------------------------------------------------------------
   // Timer 3 match registers keep only 16 bits
   task automatic match_readback();
      logic [APB_ADDR_W-1:0] addr;
      ttc_data_t             rd_val;
      for (int k = 0; k < 3; k++) begin
         addr = 8'hD0 + 8'(4 * k);            // Match 1 to 3
         apb_write(addr, 32'hFFFF_FFFF);
         apb_read(addr, rd_val);
         check_data("match_rb", 32'h0000_FFFF, rd_val);
      end
   endtask

   // Timer 2 with only match 2 enabled, a match 1 event must stay masked
   task automatic irq_mask_test();
      ttc_data_t rd_val;
      apb_write(8'h94, 32'h0000_0100);        // Match 2 far past the idle
      apb_write(8'h84, 32'h0000_0018);        // Reset, run, match enable
      repeat (16) @(negedge pclk);            // Count passes match 1 = 3
      check_irq("irq_mask", '0, interrupt);
      apb_read(8'h9C, rd_val);
      check_data("irq_mask", 32'h0000_0002, rd_val);  // Match 1 bit only
      apb_write(8'h84, 32'h0000_0001);        // Stop
   endtask

   // ------------------------------------------------------------------------
   // Main sequence
   // ------------------------------------------------------------------------
   initial begin
      int        fd;
      int        n_fields;
      string     line;
      string     name;
      string     op;
      ttc_data_t arg_a;
      ttc_data_t arg_b;
      ttc_data_t rd_val;

      void'($urandom(32'ha57558e0));
      pclk    = 1'b0;
      rst     = 1'b1;
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
      paddr   = '0;
      pwdata  = '0;
      num_ops = 0;
      repeat (RST_CYCLES) @(negedge pclk);
      rst = 1'b0;
      check_data("reset", '0, prdata);        // Idle bus reads zero
      check_irq("reset", '0, interrupt);

      fd = $fopen("verif/ttc_vectors.txt", "r");
      if (fd == 0) begin
         $display("could not open verif/ttc_vectors.txt");
         end_with_failure();
      end else begin
         while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            n_fields = $sscanf(line, "%s %s %h %h", name, op, arg_a, arg_b);
            // Comment and blank lines skipped
            if (line.len() > 0 && line.getc(0) != "#" && n_fields == 4) begin
               num_ops++;
               if (op == "W") begin
                  apb_write(arg_a[APB_ADDR_W-1:0], arg_b);
               end else if (op == "R") begin
                  apb_read(arg_a[APB_ADDR_W-1:0], rd_val);
                  check_data(name, arg_b, rd_val);
               end else if (op == "C") begin
                  repeat (arg_a) @(negedge pclk);
               end else if (op == "I") begin
                  wait_irq(name, ttc_irq_t'(arg_a), int'(arg_b));
               end else begin
                  $display("unknown operation %s in test %s", op, name);
                  end_with_failure();
               end
            end
         end
         $fclose(fd);
         if (num_ops > 0) begin
            match_readback();
            irq_mask_test();
            $display("all tests passed");
            $finish;
         end else begin
            $display("vector file holds no operations");
            end_with_failure();
         end
      end
   end

endmodule

// File: verif/ttc_vectors.txt
# test op a b, all numbers hex
# W addr data | R addr expected | C cycles 0 | I irq_vector timeout_cycles
regs R 40 00000000
regs R 44 00000001
regs R 48 00000000
regs R 4C 00000000
regs R 50 00000000
regs R 54 00000000
regs R 58 00000000
regs R 5C 00000000
regs R 60 00000000
mask W C0 FFFFFFFF
mask R C0 0000007F
mask W C4 FFFFFFFF
mask R C4 0000006F
mask W CC FFFFFFFF
mask R CC 0000FFFF
mask W E0 FFFFFFFF
mask R E0 0000003F
unmapped R 04 00000000
unmapped R 70 00000000
cntrl W 44 00000010
cntrl C 20 0
cntrl W 44 00000001
cntrl R 48 00000023
cntrl R 48 00000023
cntrl W 44 00000011
cntrl R 48 00000000
intvl W 4C 00000005
intvl W 60 00000001
intvl W 44 00000012
intvl I 1 1388
intvl W 44 00000003
intvl R 5C 00000001
intvl R 5C 00000000
intvl I 0 1388
match W 90 00000003
match W 94 00000006
match W A0 00000004
match W 84 00000018
match I 2 1388
match W 84 00000009
match C 4 0
match R 9C 00000006
pre W C0 00000003
pre W CC 00000003
pre W E0 00000001
pre W C4 00000012
pre C 4 0
pre R DC 00000000
pre I 4 1388
pre W C4 00000003
pre R DC 00000001
ovf W 60 00000010
ovf W 44 00000010
ovf I 1 11170
ovf R 5C 00000010

// File: ttc_lite.f
rtl/ttc_pkg.sv
rtl/ttc_prescaler.sv
rtl/ttc_timer_counter.sv
rtl/ttc_apb_regif.sv
rtl/ttc_lite.sv
verif/ttc_lite_tb.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = ttc_lite_tb
FILELIST = ttc_lite.f
OBJDIR   = obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP)

clean:
	rm -rf $(OBJDIR)
